//--- source/div_pkg.sv
`default_nettype none

package div_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int data_width = 32;

    // bit index of a data word
    localparam int pos_width = 5;

    // step count plus one borrow bit
    localparam int count_width = 6;

    // pipeline code fields
    localparam int op_type_width = 4;
    localparam int op_subtype_width = 5;

    // ==============================
    // operation codes
    // ==============================
    localparam logic [op_type_width-1:0] op_type_div = 4'd2;

    localparam logic [op_subtype_width-1:0] sub_div_signed = 5'd0;
    localparam logic [op_subtype_width-1:0] sub_mod_signed = 5'd1;
    localparam logic [op_subtype_width-1:0] sub_div_unsigned = 5'd2;
    localparam logic [op_subtype_width-1:0] sub_mod_unsigned = 5'd3;

    // ==============================
    // controller states
    // ==============================
    typedef enum logic [1:0]
    {
        st_idle   = 2'd0,
        st_align  = 2'd1,
        st_divide = 2'd2,
        st_hold   = 2'd3
    } div_state_t;

endpackage

`default_nettype wire

//--- source/div_ctrl_if.sv
`default_nettype none

interface div_ctrl_if;

    // strobes from the controller
    logic load;
    logic align;
    logic step;
    logic fix;
    logic count_load;

    // two's complement difference of the leading-one positions
    logic [div_pkg::count_width-1:0] count_value;

    // step counter state
    logic [div_pkg::count_width-1:0] count;
    logic count_neg;

    logic divisor_zero;

    modport ctl
    (
        output load, align, step, fix, count_load,
        input  count_value, count_neg, divisor_zero
    );

    modport cnt
    (
        input  count_load, step, count_value,
        output count, count_neg
    );

    modport dp
    (
        input  load, align, step, fix, count,
        output count_value, divisor_zero
    );

endinterface

`default_nettype wire

//--- source/leading_one_detector.sv
`default_nettype none

module leading_one_detector
(
    input  logic [div_pkg::data_width-1:0] din,
    output logic [div_pkg::pos_width-1:0]  pos
);

    logic [15:0] win16;
    logic [7:0]  win8;
    logic [3:0]  win4;
    logic [1:0]  win2;

    // each stage keeps the half that holds the highest one
    always_comb
    begin
        pos[4] = |din[31:16];
        win16 = pos[4] ? din[31:16] : din[15:0];

        pos[3] = |win16[15:8];
        win8 = pos[3] ? win16[15:8] : win16[7:0];

        pos[2] = |win8[7:4];
        win4 = pos[2] ? win8[7:4] : win8[3:0];

        pos[1] = |win4[3:2];
        win2 = pos[1] ? win4[3:2] : win4[1:0];

        // zero input falls through to position 0
        pos[0] = win2[1];
    end

endmodule

`default_nettype wire

//--- source/div_shift_counter.sv
`default_nettype none

module div_shift_counter
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    div_ctrl_if.cnt    ctrl
);

    logic [div_pkg::count_width-1:0] count_q;

    // ==============================
    // step count
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            count_q <= '0;
        end
        else if (ctrl.count_load)
        begin
            count_q <= ctrl.count_value;
        end
        else if (ctrl.step)
        begin
            count_q <= count_q - 1'b1;
        end
    end

    // shift distance of the trial subtraction in progress
    assign ctrl.count = count_q;

    // top bit set once the count passes below zero
    assign ctrl.count_neg = count_q[div_pkg::count_width-1];

endmodule

`default_nettype wire

//--- source/div_control_fsm.sv
`default_nettype none

module div_control_fsm
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              flush,
    input  logic [div_pkg::op_type_width-1:0] op_type,
    input  logic                              pipe_stall,
    output logic                              busy,
    div_ctrl_if.ctl                           ctrl
);

    div_pkg::div_state_t state_q;
    div_pkg::div_state_t state_d;

    logic accept;
    logic in_align;
    logic in_divide;
    logic early_finish;

    assign accept = (state_q == div_pkg::st_idle)
                    && (op_type == div_pkg::op_type_div)
                    && !pipe_stall
                    && !flush;

    assign in_align = (state_q == div_pkg::st_align);
    assign in_divide = (state_q == div_pkg::st_divide);

    // zero divisor, or dividend shorter than the divisor
    assign early_finish = ctrl.divisor_zero
                          || ctrl.count_value[div_pkg::count_width-1];

    // ==============================
    // steering strobes
    // ==============================
    assign ctrl.load = accept;
    assign ctrl.align = in_align;
    assign ctrl.count_load = in_align && !early_finish;
    assign ctrl.step = in_divide && !ctrl.count_neg;
    assign ctrl.fix = (in_align && early_finish) || (in_divide && ctrl.count_neg);

    // busy from the accept cycle until the result sits in hold
    assign busy = accept || in_align || in_divide;

    // ==============================
    // next state
    // ==============================
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            div_pkg::st_idle:
            begin
                if (accept)
                begin
                    state_d = div_pkg::st_align;
                end
            end
            div_pkg::st_align:
            begin
                if (early_finish)
                begin
                    state_d = div_pkg::st_hold;
                end
                else
                begin
                    state_d = div_pkg::st_divide;
                end
            end
            div_pkg::st_divide:
            begin
                if (ctrl.count_neg)
                begin
                    state_d = div_pkg::st_hold;
                end
            end
            div_pkg::st_hold:
            begin
                // result stays put while the pipeline is stalled
                if (!pipe_stall)
                begin
                    state_d = div_pkg::st_idle;
                end
            end
            default:
            begin
                state_d = div_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            state_q <= div_pkg::st_idle;
        end
        else
        begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

//--- source/div_datapath.sv
`default_nettype none

module div_datapath
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 flush,
    input  logic [div_pkg::op_subtype_width-1:0] op_subtype,
    input  logic [div_pkg::data_width-1:0]       din1,
    input  logic [div_pkg::data_width-1:0]       din2,
    output logic [div_pkg::data_width-1:0]       dout,
    div_ctrl_if.dp                               ctrl
);

    localparam int msb = div_pkg::data_width - 1;

    logic [msb:0] remainder_q;
    logic [msb:0] divisor_q;
    logic [msb:0] quotient_q;
    logic         dividend_sign_q;
    logic         divisor_sign_q;
    logic [div_pkg::op_subtype_width-1:0] subtype_q;

    logic [div_pkg::pos_width-1:0] rem_pos;
    logic [div_pkg::pos_width-1:0] div_pos;

    logic         signed_in;
    logic         signed_q;
    logic         quotient_sel;
    logic [msb+1:0] trial;
    logic         borrow;
    logic [msb:0] quotient_base;

    // ==============================
    // operand alignment
    // ==============================
    leading_one_detector u_rem_lod
    (
        .din (remainder_q),
        .pos (rem_pos)
    );

    leading_one_detector u_div_lod
    (
        .din (divisor_q),
        .pos (div_pos)
    );

    assign ctrl.count_value = {1'b0, rem_pos} - {1'b0, div_pos};
    assign ctrl.divisor_zero = (divisor_q == '0);

    assign signed_in = (op_subtype == div_pkg::sub_div_signed)
                       || (op_subtype == div_pkg::sub_mod_signed);
    assign signed_q = (subtype_q == div_pkg::sub_div_signed)
                      || (subtype_q == div_pkg::sub_mod_signed);
    assign quotient_sel = (subtype_q == div_pkg::sub_div_signed)
                          || (subtype_q == div_pkg::sub_div_unsigned);

    // trial subtraction of the divisor shifted up by the current count
    assign trial = {1'b0, remainder_q}
                   - ({1'b0, divisor_q} << ctrl.count[div_pkg::pos_width-1:0]);
    assign borrow = trial[msb+1];

    // quotient restarts from zero in the align cycle
    assign quotient_base = ctrl.align ? '0 : quotient_q;

    // ==============================
    // registers
    // ==============================
    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            remainder_q <= '0;
            divisor_q <= '0;
            quotient_q <= '0;
            dividend_sign_q <= 1'b0;
            divisor_sign_q <= 1'b0;
            subtype_q <= div_pkg::sub_div_signed;
        end
        else if (ctrl.load)
        begin
            // a negative operand is negated only for signed subtypes
            remainder_q <= (signed_in && din1[msb]) ? -din1 : din1;
            divisor_q <= (signed_in && din2[msb]) ? -din2 : din2;
            dividend_sign_q <= din1[msb];
            divisor_sign_q <= din2[msb];
            subtype_q <= op_subtype;
        end
        else if (ctrl.fix)
        begin
            if (signed_q && dividend_sign_q)
            begin
                remainder_q <= -remainder_q;
            end
            if (signed_q && (dividend_sign_q ^ divisor_sign_q))
            begin
                quotient_q <= -quotient_base;
            end
            else
            begin
                quotient_q <= quotient_base;
            end
        end
        else if (ctrl.align)
        begin
            quotient_q <= '0;
        end
        else if (ctrl.step)
        begin
            quotient_q <= {quotient_q[msb-1:0], ~borrow};
            if (!borrow)
            begin
                remainder_q <= trial[msb:0];
            end
        end
    end

    assign dout = quotient_sel ? quotient_q : remainder_q;

endmodule

`default_nettype wire

//--- source/divider_unit.sv
`default_nettype none

module divider_unit
(
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [div_pkg::op_type_width-1:0]    op_type,
    input  logic [div_pkg::op_subtype_width-1:0] op_subtype,
    input  logic                                 pipe_stall,
    input  logic                                 flush,
    input  logic [div_pkg::data_width-1:0]       din1,
    input  logic [div_pkg::data_width-1:0]       din2,
    output logic                                 busy,
    output logic [div_pkg::data_width-1:0]       dout
);

    div_ctrl_if ctrl ();

    // ==============================
    // control
    // ==============================
    div_control_fsm u_control_fsm
    (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .op_type    (op_type),
        .pipe_stall (pipe_stall),
        .busy       (busy),
        .ctrl       (ctrl.ctl)
    );

    div_shift_counter u_shift_counter
    (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .ctrl  (ctrl.cnt)
    );

    // ==============================
    // datapath
    // ==============================
    div_datapath u_datapath
    (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .op_subtype (op_subtype),
        .din1       (din1),
        .din2       (din2),
        .dout       (dout),
        .ctrl       (ctrl.dp)
    );

endmodule

`default_nettype wire

//--- tb/divider_unit_tb.sv
`default_nettype none

module divider_unit_tb;

    localparam int num_random = 300;
    localparam int num_corner = 12;
    localparam int num_stall = 40;
    localparam int num_flush = 40;
    localparam int op_cycles = 40;
    localparam int max_hold = 8;
    // corner pairs run in all four subtypes and each flush case runs two operations
    localparam int num_ops = num_random + 4 * num_corner + num_stall + 2 * num_flush;
    localparam int cycle_limit = num_ops * op_cycles + num_stall * max_hold + 200;

    logic                                 clk = 1'b0;
    logic                                 reset;
    logic [div_pkg::op_type_width-1:0]    op_type;
    logic [div_pkg::op_subtype_width-1:0] op_subtype;
    logic                                 pipe_stall;
    logic                                 flush;
    logic [31:0]                          din1;
    logic [31:0]                          din2;
    logic                                 busy;
    logic [31:0]                          dout;

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;

    // zero divisors, zero dividends, divisor one, min / -1, equal operands
    logic [31:0] corner_a [num_corner] = '{32'd12345, 32'hffff_fff9, 32'd0, 32'd0,
        32'h7fff_ffff, 32'h8000_0000, 32'hffff_ff9c, 32'h8000_0000, 32'd55,
        32'hffff_ffc9, 32'h8000_0000, 32'hffff_ffff};
    logic [31:0] corner_b [num_corner] = '{32'd0, 32'd0, 32'd0, 32'hffff_fffd,
        32'd1, 32'd1, 32'd1, 32'hffff_ffff, 32'd55,
        32'hffff_ffc9, 32'h8000_0000, 32'hffff_ffff};

    divider_unit DUT
    (
        .clk        (clk),
        .reset      (reset),
        .op_type    (op_type),
        .op_subtype (op_subtype),
        .pipe_stall (pipe_stall),
        .flush      (flush),
        .din1       (din1),
        .din2       (din2),
        .busy       (busy),
        .dout       (dout)
    );

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ==============================
    // reference model and checking
    // ==============================
    function automatic logic [31:0] model_result(input logic [4:0] sub,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic        is_signed;
        logic        want_quot;
        logic        neg_a;
        logic        neg_b;
        logic [31:0] mag_a;
        logic [31:0] mag_b;
        logic [31:0] quot;
        logic [31:0] rem;
        is_signed = (sub == div_pkg::sub_div_signed) || (sub == div_pkg::sub_mod_signed);
        want_quot = (sub == div_pkg::sub_div_signed) || (sub == div_pkg::sub_div_unsigned);
        neg_a = is_signed && a[31];
        neg_b = is_signed && b[31];
        mag_a = neg_a ? -a : a;
        mag_b = neg_b ? -b : b;
        if (b == 32'd0)
        begin
            return want_quot ? 32'd0 : a;
        end
        quot = mag_a / mag_b;
        rem = mag_a % mag_b;
        quot = (neg_a ^ neg_b) ? -quot : quot;
        rem = neg_a ? -rem : rem;
        return want_quot ? quot : rem;
    endfunction

    function automatic logic [31:0] shaped_random();
        logic [31:0] value;
        value = $urandom >> ($urandom % 32);
        if ($urandom % 4 == 0)
        begin
            value = -value;
        end
        return value;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            error_count++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // ==============================
    // operation sequencing
    // ==============================
    task automatic issue(input logic [4:0] sub, input logic [31:0] a, input logic [31:0] b,
                         input logic stall);
        @(posedge clk);
        op_type <= div_pkg::op_type_div;
        op_subtype <= sub;
        din1 <= a;
        din2 <= b;
        @(negedge clk);
        check("accept busy", 32'd1, 32'(busy));
        @(posedge clk);
        pipe_stall <= stall;
        // the op code stays through a stall and hold must not accept it
        if (!stall)
        begin
            op_type <= '0;
        end
    endtask

    task automatic run_op(input string name, input logic [4:0] sub, input logic [31:0] a,
                          input logic [31:0] b, input int hold_cycles);
        logic [31:0] expected;
        int          waited;
        expected = model_result(sub, a, b);
        waited = 0;
        issue(sub, a, b, hold_cycles > 0);
        @(negedge clk);
        while (busy && waited < op_cycles)
        begin
            @(negedge clk);
            waited++;
        end
        if (busy)
        begin
            error_count++;
            $display("%s: busy still high %0d cycles after accept", name, op_cycles);
            return;
        end
        check(name, expected, dout);
        repeat (hold_cycles)
        begin
            @(negedge clk);
            check("stall busy", 32'd0, 32'(busy));
            check(name, expected, dout);
        end
        @(posedge clk);
        pipe_stall <= 1'b0;
        op_type <= '0;
    endtask

    task automatic flush_op(input int delay);
        issue(5'($urandom % 4), shaped_random(), shaped_random(), 1'b0);
        repeat (delay - 1) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check("flush busy", 32'd0, 32'(busy));
        check("flush dout", 32'd0, dout);
    endtask

    initial
    begin
        logic [div_pkg::op_type_width-1:0] other_type;
        void'($urandom(32'h30b0));
        reset = 1'b1;
        op_type = '0;
        op_subtype = '0;
        pipe_stall = 1'b0;
        flush = 1'b0;
        din1 = '0;
        din2 = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("reset busy", 32'd0, 32'(busy));
        check("reset dout", 32'd0, dout);

        // codes of other units must leave the divider idle
        repeat (20)
        begin
            @(posedge clk);
            other_type = 4'($urandom);
            if (other_type == div_pkg::op_type_div)
            begin
                other_type = other_type + 1'b1;
            end
            op_type <= other_type;
            din1 <= $urandom;
            din2 <= $urandom;
            @(negedge clk);
            check("other type busy", 32'd0, 32'(busy));
        end

        for (int i = 0; i < num_random; i++)
        begin
            run_op("random", 5'($urandom % 4), shaped_random(),
                   ($urandom % 4 == 0) ? ($urandom % 16) : shaped_random(), 0);
        end
        for (int i = 0; i < num_corner; i++)
        begin
            for (int s = 0; s < 4; s++)
            begin
                run_op("corner", 5'(s), corner_a[i], corner_b[i], 0);
            end
        end
        for (int i = 0; i < num_stall; i++)
        begin
            run_op("stall", 5'($urandom % 4), shaped_random(), shaped_random(),
                   1 + int'($urandom % max_hold));
        end
        for (int i = 0; i < num_flush; i++)
        begin
            flush_op(1 + int'($urandom % 10));
            run_op("after flush", 5'($urandom % 4), shaped_random(), shaped_random(), 0);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
source/div_pkg.sv
source/div_ctrl_if.sv
source/leading_one_detector.sv
source/div_shift_counter.sv
source/div_control_fsm.sv
source/div_datapath.sv
source/divider_unit.sv
tb/divider_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= divider_unit_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
